// File: ttt_pkg.sv
// shared types, status codes and the table of winning lines for the tic-tac-toe controller
package ttt_pkg;

    // one bit per square, square 8 is the top-left corner in reading order
    typedef logic [8:0] board_t;
    typedef logic [7:0] ascii_t;

    typedef enum logic [3:0] {
        START  = 4'd0,
        TURN_X = 4'd1,
        ERR_X  = 4'd2,
        CHKV_X = 4'd3,
        CHKW_X = 4'd4,
        WIN_X  = 4'd5,
        TURN_O = 4'd6,
        ERR_O  = 4'd7,
        CHKV_O = 4'd8,
        CHKW_O = 4'd9,
        WIN_O  = 4'd10,
        CATS   = 4'd11
    } game_state_t;

    // ####################
    // status characters
    localparam ascii_t ASCII_X    = 8'h58;
    localparam ascii_t ASCII_O    = 8'h4f;
    localparam ascii_t ASCII_C    = 8'h43;
    localparam ascii_t ASCII_E    = 8'h45;
    localparam ascii_t ASCII_NONE = 8'h6e;

    // ####################
    // rows top to bottom, columns left to right, then both diagonals
    localparam int NUM_LINES = 8;
    localparam board_t WIN_LINES [NUM_LINES] = '{
        9'b111_000_000,
        9'b000_111_000,
        9'b000_000_111,
        9'b100_100_100,
        9'b010_010_010,
        9'b001_001_001,
        9'b100_010_001,
        9'b001_010_100
    };

    // O tiles blink once every O_BLINK_DIV flash ticks
    localparam int O_BLINK_DIV = 3;
    typedef logic [$clog2(O_BLINK_DIV)-1:0] blink_cnt_t;
    localparam blink_cnt_t BLINK_LAST = blink_cnt_t'(O_BLINK_DIV - 1);

endpackage

// File: ttt_board.sv
// board registers for occupancy and owner, the captured selection
// and the legality check of a move
module ttt_board (
    input  logic            clk,
    input  logic            reset,
    input  ttt_pkg::board_t sel_pos,
    input  logic            sel_load,
    input  logic            commit,
    input  logic            commit_o,
    output ttt_pkg::board_t occ_square,
    output ttt_pkg::board_t occ_player,
    output logic            move_illegal
);
    import ttt_pkg::*;

    board_t sel_q;
    logic   sel_one_hot;
    logic   sel_taken;

    // selection is only consumed in the check state right after a load
    always_ff @(posedge clk) begin
        if (sel_load) begin
            sel_q <= sel_pos;
        end
    end

    // owner bit is 1 for an X tile
    always_ff @(posedge clk) begin
        if (reset) begin
            occ_square <= '0;
            occ_player <= '0;
        end else if (commit) begin
            occ_square <= occ_square | sel_q;
            occ_player <= (occ_player & ~sel_q) | (commit_o ? '0 : sel_q);
        end
    end

    // exactly one square, and that square still free
    assign sel_one_hot  = (sel_q != '0) && ((sel_q & (sel_q - 1'b1)) == '0);
    assign sel_taken    = |(sel_q & occ_square);
    assign move_illegal = !sel_one_hot || sel_taken;

    // ####################
    // checks

    // the FSM only writes a tile after the check has passed
    a_no_illegal_commit: assert property (
        @(posedge clk) disable iff (reset)
        commit |-> !move_illegal
    );

    a_owner_needs_tile: assert property (
        @(posedge clk) disable iff (reset)
        (occ_player & ~occ_square) == '0
    );

endmodule

// File: ttt_win_detect.sv
// line detection for each player, full-board detection
// and the mask of the first winning line
module ttt_win_detect (
    input  ttt_pkg::board_t occ_square,
    input  ttt_pkg::board_t occ_player,
    output logic            x_wins,
    output logic            o_wins,
    output logic            board_full,
    output ttt_pkg::board_t win_line
);
    import ttt_pkg::*;

    board_t               x_tiles;
    board_t               o_tiles;
    logic [NUM_LINES-1:0] x_line;
    logic [NUM_LINES-1:0] o_line;

    assign x_tiles = occ_square & occ_player;
    assign o_tiles = occ_square & ~occ_player;

    // a line is complete when all three of its squares hold the same tile
    always_comb begin
        for (int i = 0; i < NUM_LINES; i++) begin
            x_line[i] = (x_tiles & WIN_LINES[i]) == WIN_LINES[i];
            o_line[i] = (o_tiles & WIN_LINES[i]) == WIN_LINES[i];
        end
    end

    assign x_wins     = |x_line;
    assign o_wins     = |o_line;
    assign board_full = &occ_square;

    // walk the table backwards so the earliest entry ends up in win_line
    always_comb begin
        win_line = '0;
        for (int i = NUM_LINES - 1; i >= 0; i--) begin
            if (x_line[i] || o_line[i]) begin
                win_line = WIN_LINES[i];
            end
        end
    end

endmodule

// File: ttt_game_fsm.sv
// turn state machine for X and O, the board control strobes,
// the turn outputs and the status byte
module ttt_game_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 button_x,
    input  logic                 button_o,
    input  logic                 move_illegal,
    input  logic                 x_wins,
    input  logic                 o_wins,
    input  logic                 board_full,
    output ttt_pkg::game_state_t game_state,
    output logic                 sel_load,
    output logic                 commit,
    output logic                 commit_o,
    output logic                 turn_x,
    output logic                 turn_o,
    output ttt_pkg::ascii_t      game_st_ascii
);
    import ttt_pkg::*;

    game_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            game_state <= START;
        end else begin
            game_state <= state_next;
        end
    end

    // ####################
    // next state and board strobes
    always_comb begin
        state_next = game_state;
        sel_load   = 1'b0;
        commit     = 1'b0;
        commit_o   = 1'b0;
        case (game_state)
            START: state_next = TURN_X;
            TURN_X: begin
                if (button_o) begin
                    state_next = ERR_X;
                end else if (button_x) begin
                    state_next = CHKV_X;
                    sel_load   = 1'b1;
                end
            end
            // only the player's own button gets out of the error state
            ERR_X: begin
                if (button_x) begin
                    state_next = CHKV_X;
                    sel_load   = 1'b1;
                end
            end
            CHKV_X: begin
                if (move_illegal) begin
                    state_next = ERR_X;
                end else begin
                    state_next = CHKW_X;
                    commit     = 1'b1;
                end
            end
            // a win outranks a full board
            CHKW_X: begin
                if (x_wins) begin
                    state_next = WIN_X;
                end else if (board_full) begin
                    state_next = CATS;
                end else begin
                    state_next = TURN_O;
                end
            end
            TURN_O: begin
                if (button_x) begin
                    state_next = ERR_O;
                end else if (button_o) begin
                    state_next = CHKV_O;
                    sel_load   = 1'b1;
                end
            end
            ERR_O: begin
                if (button_o) begin
                    state_next = CHKV_O;
                    sel_load   = 1'b1;
                end
            end
            CHKV_O: begin
                commit_o = 1'b1;
                if (move_illegal) begin
                    state_next = ERR_O;
                end else begin
                    state_next = CHKW_O;
                    commit     = 1'b1;
                end
            end
            CHKW_O: begin
                if (o_wins) begin
                    state_next = WIN_O;
                end else if (board_full) begin
                    state_next = CATS;
                end else begin
                    state_next = TURN_X;
                end
            end
            // WIN_X, WIN_O and CATS hold until reset
            default: state_next = game_state;
        endcase
    end

    // ####################
    // output decode
    assign turn_x = (game_state == TURN_X) || (game_state == ERR_X);
    assign turn_o = (game_state == TURN_O) || (game_state == ERR_O);

    always_comb begin
        case (game_state)
            ERR_X, ERR_O: game_st_ascii = ASCII_E;
            WIN_X:        game_st_ascii = ASCII_X;
            WIN_O:        game_st_ascii = ASCII_O;
            CATS:         game_st_ascii = ASCII_C;
            default:      game_st_ascii = ASCII_NONE;
        endcase
    end

    a_one_turn: assert property (
        @(posedge clk) disable iff (reset)
        !(turn_x && turn_o)
    );

endmodule

// File: ttt_flash.sv
// flash phase registers for the O tiles and the winning line,
// and the displayed board built from them
module ttt_flash (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flash_tick,
    input  ttt_pkg::game_state_t game_state,
    input  ttt_pkg::board_t      occ_square,
    input  ttt_pkg::board_t      occ_player,
    input  ttt_pkg::board_t      win_line,
    output ttt_pkg::board_t      occ_pos
);
    import ttt_pkg::*;

    blink_cnt_t tick_cnt;
    logic       o_phase;
    logic       line_phase;
    logic       in_win;
    board_t     x_tiles;
    board_t     o_tiles;
    board_t     base_pos;

    // O tiles start visible and toggle on every third tick
    always_ff @(posedge clk) begin
        if (reset) begin
            tick_cnt <= '0;
            o_phase  <= 1'b1;
        end else if (flash_tick) begin
            if (tick_cnt == BLINK_LAST) begin
                tick_cnt <= '0;
                o_phase  <= ~o_phase;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign in_win = (game_state == WIN_X) || (game_state == WIN_O);

    // the winning line flips on every tick, and only once a winner is known
    always_ff @(posedge clk) begin
        if (reset) begin
            line_phase <= 1'b0;
        end else if (!in_win) begin
            line_phase <= 1'b0;
        end else if (flash_tick) begin
            line_phase <= ~line_phase;
        end
    end

    assign x_tiles  = occ_square & occ_player;
    assign o_tiles  = occ_square & ~occ_player;
    assign base_pos = x_tiles | (o_phase ? o_tiles : '0);
    assign occ_pos  = base_pos ^ (line_phase ? win_line : '0);

endmodule

// File: tictactoe.sv
// top level of the tic-tac-toe controller with board, win detection,
// game FSM and display flashing
module tictactoe (
    input  logic            clk,
    input  logic            reset,
    input  ttt_pkg::board_t sel_pos,
    input  logic            button_x,
    input  logic            button_o,
    input  logic            flash_tick,
    output logic            turn_x,
    output logic            turn_o,
    output ttt_pkg::board_t occ_square,
    output ttt_pkg::board_t occ_player,
    output ttt_pkg::board_t occ_pos,
    output ttt_pkg::ascii_t game_st_ascii
);
    import ttt_pkg::*;

    logic        sel_load;
    logic        commit;
    logic        commit_o;
    logic        move_illegal;
    logic        x_wins;
    logic        o_wins;
    logic        board_full;
    board_t      win_line;
    game_state_t game_state;

    ttt_board i_board (
        .clk          (clk),
        .reset        (reset),
        .sel_pos      (sel_pos),
        .sel_load     (sel_load),
        .commit       (commit),
        .commit_o     (commit_o),
        .occ_square   (occ_square),
        .occ_player   (occ_player),
        .move_illegal (move_illegal)
    );

    ttt_win_detect i_win_detect (
        .occ_square (occ_square),
        .occ_player (occ_player),
        .x_wins     (x_wins),
        .o_wins     (o_wins),
        .board_full (board_full),
        .win_line   (win_line)
    );

    ttt_game_fsm i_game_fsm (
        .clk           (clk),
        .reset         (reset),
        .button_x      (button_x),
        .button_o      (button_o),
        .move_illegal  (move_illegal),
        .x_wins        (x_wins),
        .o_wins        (o_wins),
        .board_full    (board_full),
        .game_state    (game_state),
        .sel_load      (sel_load),
        .commit        (commit),
        .commit_o      (commit_o),
        .turn_x        (turn_x),
        .turn_o        (turn_o),
        .game_st_ascii (game_st_ascii)
    );

    ttt_flash i_flash (
        .clk        (clk),
        .reset      (reset),
        .flash_tick (flash_tick),
        .game_state (game_state),
        .occ_square (occ_square),
        .occ_player (occ_player),
        .win_line   (win_line),
        .occ_pos    (occ_pos)
    );

endmodule

// File: tb_clock.sv
// clock and power-on reset generator for the testbench
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: tictactoe_tb.sv
// testbench top for the tic-tac-toe controller, runs the stimulus records
// with presses, flash ticks and resets and checks the outputs of each
module tictactoe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ttt_pkg::*;

    localparam int          MAX_RECS  = 64;
    localparam int          DRIVE_DLY = 1;
    localparam int          MAX_GAP   = 3;
    localparam int unsigned SEED      = 32'h035192fc;

    logic   clk;
    logic   por_reset;
    logic   tb_reset;
    logic   reset;
    board_t sel_pos;
    logic   button_x;
    logic   button_o;
    logic   flash_tick;
    logic   turn_x;
    logic   turn_o;
    board_t occ_square;
    board_t occ_player;
    board_t occ_pos;
    ascii_t game_st_ascii;

    // one entry per stimulus record
    string  rec_name   [MAX_RECS];
    string  rec_act    [MAX_RECS];
    int     rec_arg    [MAX_RECS];
    ascii_t exp_ascii  [MAX_RECS];
    board_t exp_square [MAX_RECS];
    board_t exp_player [MAX_RECS];
    logic   exp_turn_x [MAX_RECS];
    logic   exp_turn_o [MAX_RECS];
    logic   chk_pos    [MAX_RECS];
    board_t exp_pos    [MAX_RECS];

    int     num_recs;
    int     rec_cycles;
    int     cycle_limit;
    int     cycle_cnt = 0;
    int     pass_cnt;
    int     fail_cnt;
    int     test_errs;
    string  cur_name;

    tb_clock i_clock (
        .clk   (clk),
        .reset (por_reset)
    );

    assign reset = por_reset | tb_reset;

    tictactoe i_tictactoe (
        .clk           (clk),
        .reset         (reset),
        .sel_pos       (sel_pos),
        .button_x      (button_x),
        .button_o      (button_o),
        .flash_tick    (flash_tick),
        .turn_x        (turn_x),
        .turn_o        (turn_o),
        .occ_square    (occ_square),
        .occ_player    (occ_player),
        .occ_pos       (occ_pos),
        .game_st_ascii (game_st_ascii)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ####################
    // stimulus file
    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        string name;
        string act;
        int    arg;
        int    asc;
        int    sq;
        int    pl;
        int    tx_v;
        int    to_v;
        int    cp;
        int    pos;
        fd = $fopen("tictactoe_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_recs < MAX_RECS) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %h %b %b %b %h",
                                name, act, arg, asc, sq, pl, tx_v, to_v, cp, pos);
                    if (n == 10) begin
                        rec_name[num_recs]   = name;
                        rec_act[num_recs]    = act;
                        rec_arg[num_recs]    = arg;
                        exp_ascii[num_recs]  = ascii_t'(asc);
                        exp_square[num_recs] = board_t'(sq);
                        exp_player[num_recs] = board_t'(pl);
                        exp_turn_x[num_recs] = tx_v[0];
                        exp_turn_o[num_recs] = to_v[0];
                        chk_pos[num_recs]    = cp[0];
                        exp_pos[num_recs]    = board_t'(pos);
                        // worst case length of the record in cycles
                        if (act == "X" || act == "O") begin
                            rec_cycles += 3 + MAX_GAP;
                        end else if (act == "T") begin
                            rec_cycles += 2 * arg;
                        end else begin
                            rec_cycles += 3;
                        end
                        num_recs++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ####################
    // drivers
    task automatic next_edge();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom_range(MAX_GAP, 0);
        repeat (gap) next_edge();
    endtask

    task automatic press_button(input logic is_o, input board_t pos);
        idle_gap();
        sel_pos  = pos;
        button_x = !is_o;
        button_o = is_o;
        next_edge();
        button_x = 1'b0;
        button_o = 1'b0;
        // the outcome settles two edges after the press is sampled
        repeat (2) next_edge();
    endtask

    task automatic pulse_flash(input int count);
        repeat (count) begin
            flash_tick = 1'b1;
            next_edge();
            flash_tick = 1'b0;
            next_edge();
        end
    endtask

    task automatic apply_reset();
        tb_reset = 1'b1;
        repeat (2) next_edge();
        tb_reset = 1'b0;
        // START moves on to TURN_X at the next edge
        next_edge();
    endtask

    // ####################
    // compare tasks
    task automatic check_ascii(input string what, input ascii_t exp, input ascii_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s expected '%c' (%h) actual '%c' (%h)",
                     cur_name, what, exp, exp, act, act);
            test_errs++;
        end
    endtask

    task automatic check_board(input string what, input board_t exp, input board_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s expected %h actual %h", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s expected %b actual %b", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic run_record(input int r);
        cur_name  = rec_name[r];
        test_errs = 0;
        if (rec_act[r] == "X") begin
            press_button(1'b0, board_t'(rec_arg[r]));
        end else if (rec_act[r] == "O") begin
            press_button(1'b1, board_t'(rec_arg[r]));
        end else if (rec_act[r] == "T") begin
            pulse_flash(rec_arg[r]);
        end else if (rec_act[r] == "R") begin
            apply_reset();
        end else begin
            $display("[FAIL] %s has an action that the testbench does not know", cur_name);
            test_errs++;
        end
        check_ascii("game_st_ascii", exp_ascii[r], game_st_ascii);
        check_board("occ_square", exp_square[r], occ_square);
        check_board("occ_player", exp_player[r], occ_player);
        check_bit("turn_x", exp_turn_x[r], turn_x);
        check_bit("turn_o", exp_turn_o[r], turn_o);
        if (chk_pos[r]) begin
            check_board("occ_pos", exp_pos[r], occ_pos);
        end
        if (test_errs == 0) begin
            pass_cnt++;
            $display("[PASS] %s", cur_name);
        end else begin
            fail_cnt++;
        end
    endtask

    initial begin
        sel_pos     = '0;
        button_x    = 1'b0;
        button_o    = 1'b0;
        flash_tick  = 1'b0;
        tb_reset    = 1'b0;
        num_recs    = 0;
        rec_cycles  = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        test_errs   = 0;
        cycle_limit = 0;
        void'($urandom(SEED));
        load_stimulus();
        // the power-on reset counts as one more record
        cycle_limit = 2 * (rec_cycles + 20);
        if (num_recs == 0) begin
            $display("no stimulus records could be read from tictactoe_stim.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            next_edge();
            while (reset) begin
                next_edge();
            end
            for (int r = 0; r < num_recs; r++) begin
                run_record(r);
            end
            $display("%0d tests run, %0d passed, %0d failed", num_recs, pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

// File: tictactoe_stim.txt
# name action arg game_st_ascii occ_square occ_player turn_x turn_o check_pos occ_pos
# action X or O presses with arg as sel_pos, T gives arg flash ticks, R resets; hex values
reset_start      R 000 6e 000 000 1 0 1 000
x_center         X 010 6e 010 010 0 1 1 010
o_corner         O 100 6e 110 010 1 0 1 110
wrong_button_o   O 000 45 110 010 1 0 0 000
recover_x        X 001 6e 111 011 0 1 0 000
occupied_o       O 010 45 111 011 0 1 0 000
recover_o        O 004 6e 115 011 1 0 0 000
two_squares_x    X 00a 45 115 011 1 0 0 000
err_ignores_o    O 000 45 115 011 1 0 0 000
recover_x2       X 040 6e 155 051 0 1 0 000
alternate_o      O 002 6e 157 051 1 0 1 157
empty_select_x   X 000 45 157 051 1 0 0 000
recover_x3       X 020 6e 177 071 0 1 1 177
reset_row_game   R 000 6e 000 000 1 0 1 000
row_x1           X 100 6e 100 100 0 1 0 000
row_o1           O 010 6e 110 100 1 0 0 000
row_x2           X 080 6e 190 180 0 1 0 000
row_o2           O 001 6e 191 180 1 0 0 000
row_x_wins       X 040 58 1d1 1c0 0 0 1 1d1
win_ignores_x    X 004 58 1d1 1c0 0 0 0 000
win_ignores_o    O 002 58 1d1 1c0 0 0 1 1d1
flash_line_on    T 1   58 1d1 1c0 0 0 1 011
flash_line_off   T 1   58 1d1 1c0 0 0 1 1d1
flash_o_off      T 1   58 1d1 1c0 0 0 1 000
flash_o_hidden   T 1   58 1d1 1c0 0 0 1 1c0
flash_o_back     T 2   58 1d1 1c0 0 0 1 1d1
reset_diag_game  R 000 6e 000 000 1 0 1 000
diag_x1          X 020 6e 020 020 0 1 0 000
diag_o1          O 100 6e 120 020 1 0 0 000
diag_x2          X 004 6e 124 024 0 1 0 000
diag_o2          O 010 6e 134 024 1 0 0 000
diag_x3          X 080 6e 1b4 0a4 0 1 0 000
diag_o_wins      O 001 4f 1b5 0a4 0 0 1 1b5
diag_flash       T 1   4f 1b5 0a4 0 0 1 0a4
reset_cats_game  R 000 6e 000 000 1 0 1 000
cats_x1          X 100 6e 100 100 0 1 0 000
cats_o1          O 010 6e 110 100 1 0 0 000
cats_x2          X 001 6e 111 101 0 1 0 000
cats_o2          O 080 6e 191 101 1 0 0 000
cats_x3          X 002 6e 193 103 0 1 0 000
cats_o3          O 004 6e 197 103 1 0 0 000
cats_x4          X 040 6e 1d7 143 0 1 0 000
cats_o4          O 008 6e 1df 143 1 0 0 000
cats_full        X 020 43 1ff 163 0 0 1 1ff
cats_flash       T 3   43 1ff 163 0 0 1 163

// File: filelist.f
ttt_pkg.sv
ttt_board.sv
ttt_win_detect.sv
ttt_game_fsm.sv
ttt_flash.sv
tictactoe.sv
tb_clock.sv
tictactoe_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tictactoe_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
